// ==== font.mem ====
// Font glyphs, one hex byte per glyph line, 16 lines per character, MSB is the leftmost pixel
// @ marks the character code times 16; characters not listed read as zero
@210
00 00 18 3C 3C 3C 18 18
18 00 18 18 00 00 00 00
@300
00 00 7C C6 C6 CE DE F6
E6 C6 C6 7C 00 00 00 00
@310
00 00 18 38 78 18 18 18
18 18 18 7E 00 00 00 00
@410
00 00 10 38 6C C6 C6 FE
C6 C6 C6 C6 00 00 00 00
@420
00 00 FC 66 66 66 7C 66
66 66 66 FC 00 00 00 00
@480
00 00 C6 C6 C6 C6 FE C6
C6 C6 C6 C6 00 00 00 00
@4F0
00 00 7C C6 C6 C6 C6 C6
C6 C6 C6 7C 00 00 00 00

// ==== src.f ====
hdl/TextTerminalPkg.sv
hdl/CommandDecoder.sv
hdl/CursorWriter.sv
hdl/TextRam.sv
hdl/FontRom.sv
hdl/PixelFetcher.sv
hdl/TextTerminal.sv
tb/TextTerminalTb.sv

// ==== Bender.yml ====
package:
  name: text_terminal

sources:
  - files:
      - hdl/TextTerminalPkg.sv
      - hdl/CommandDecoder.sv
      - hdl/CursorWriter.sv
      - hdl/TextRam.sv
      - hdl/FontRom.sv
      - hdl/PixelFetcher.sv
      - hdl/TextTerminal.sv
  - target: test
    files:
      - tb/TextTerminalTb.sv

// ==== tb/TextTerminalTb.sv ====
// Table-driven testbench for the text terminal with cursor, screen and font models
`timescale 1ns/1ps

module TextTerminalTb;
	import TextTerminalPkg::*;

	typedef enum logic [1:0] {
		KindSend,
		KindRead,
		KindIdle
	} StepKind_t;

	// Send rows carry the cursor expected after the byte, read rows the cell and line
	typedef struct packed {
		logic [2:0] Test;
		StepKind_t Kind;
		logic [7:0] Data;
		logic [ColumnWidth-1:0] Column;
		logic [RowWidth-1:0] Row;
		logic [LineWidth-1:0] Line;
	} Step_t;

	localparam int CursorTimeout = 8;
	localparam int DrainTimeout = 8;
	// Request edge plus three pipeline edges, seen on the fourth falling edge
	localparam int ReadLatency = 4;

	logic Clock;
	logic Reset;
	logic AnalyzeRequest;
	logic [7:0] DataFromUart;
	logic ReadRequest;
	logic [ColumnWidth-1:0] ReadColumn;
	logic [RowWidth-1:0] ReadRow;
	logic [LineWidth-1:0] ReadLine;
	logic [7:0] Pixels;
	logic [2:0] ColorForeground;
	logic [2:0] ColorBackground;
	logic [ColumnWidth-1:0] CursorColumn;
	logic [RowWidth-1:0] CursorRow;

	// Reference models
	logic [7:0] FontModel [FontDepth];
	logic [7:0] ScreenModel [TextDepth];
	logic [ColumnWidth-1:0] ModelColumn;
	logic [RowWidth-1:0] ModelRow;

	// Reads in flight, each with its due cycle
	int DueCycle [$];
	logic [7:0] DuePixels [$];
	Step_t Steps [$];
	string TestNames [1:6];
	int Cycle;
	int Checks;
	int Errors;
	int TestErrors;
	int TestsPassed;
	int TestsFailed;

	TextTerminal DUT (
		.Clock(Clock),
		.Reset(Reset),
		.AnalyzeRequest_i(AnalyzeRequest),
		.DataFromUart_i(DataFromUart),
		.ReadRequest_i(ReadRequest),
		.Column_i(ReadColumn),
		.Row_i(ReadRow),
		.Line_i(ReadLine),
		.Pixels_o(Pixels),
		.ColorForeground_o(ColorForeground),
		.ColorBackground_o(ColorBackground),
		.CursorColumn_o(CursorColumn),
		.CursorRow_o(CursorRow)
	);

	// 8 ns period
	always #4 Clock = ~Clock;

	task automatic CheckValue(input string Name, input logic [7:0] Got,
		input logic [7:0] Expected);
		Checks++;
		assert (Got === Expected) else begin
			$display("CHECK FAILED %s expected %h got %h at cycle %0d", Name, Expected, Got,
				Cycle);
			TestErrors++;
		end
	endtask

	// Falling edge, then any read results due on it
	task automatic NextCycle();
		logic [7:0] Expected;
		@(negedge Clock);
		Cycle++;
		while (DueCycle.size() > 0 && DueCycle[0] == Cycle) begin
			DueCycle.delete(0);
			Expected = DuePixels.pop_front();
			CheckValue("Pixels_o", Pixels, Expected);
			CheckValue("ColorForeground_o", ColorForeground, ColorForegroundText);
			CheckValue("ColorBackground_o", ColorBackground, ColorBackgroundText);
		end
	endtask

	// Cursor and screen rules of the terminal
	function automatic void ApplyModel(input logic [7:0] Data);
		if (Data == CodeNewLine) begin
			ModelRow = (ModelRow == ScreenRows - 1) ? '0 : ModelRow + 1'b1;
		end else if (Data == CodeCarriageReturn) begin
			ModelColumn = '0;
		end else if (Data == CodeHome) begin
			ModelColumn = '0;
			ModelRow = '0;
		end else if (Data == CodeBackspace) begin
			// Column 0 backs up to the end of the row above
			if (ModelColumn == 0) begin
				ModelColumn = ColumnWidth'(ScreenColumns - 1);
				ModelRow = (ModelRow == 0) ? RowWidth'(ScreenRows - 1) : ModelRow - 1'b1;
			end else begin
				ModelColumn = ModelColumn - 1'b1;
			end
		end else if (!Data[7]) begin
			ScreenModel[ModelRow * ScreenColumns + ModelColumn] = Data;
			if (ModelColumn == ScreenColumns - 1) begin
				ModelColumn = '0;
				ModelRow = (ModelRow == ScreenRows - 1) ? '0 : ModelRow + 1'b1;
			end else begin
				ModelColumn = ModelColumn + 1'b1;
			end
		end
	endfunction

	// Strobe, wait for the cursor, then one idle cycle
	task automatic SendByte(input Step_t Entry);
		int Waited;
		AnalyzeRequest = 1'b1;
		DataFromUart = Entry.Data;
		ApplyModel(Entry.Data);
		NextCycle();
		AnalyzeRequest = 1'b0;
		Waited = 0;
		while ((CursorColumn !== Entry.Column || CursorRow !== Entry.Row)
			&& Waited < CursorTimeout) begin
			NextCycle();
			Waited++;
		end
		if (CursorColumn !== Entry.Column || CursorRow !== Entry.Row) begin
			$display("Cursor never reached column %0d row %0d after byte %h",
				Entry.Column, Entry.Row, Entry.Data);
			TestErrors++;
		end
		NextCycle();
		CheckValue("CursorColumn_o", CursorColumn, ModelColumn);
		CheckValue("CursorRow_o", CursorRow, ModelRow);
	endtask

	// One-cycle request, expected byte queued for its due cycle
	task automatic ReadCell(input Step_t Entry);
		logic [7:0] Char;
		Char = ScreenModel[Entry.Row * ScreenColumns + Entry.Column];
		ReadRequest = 1'b1;
		ReadColumn = Entry.Column;
		ReadRow = Entry.Row;
		ReadLine = Entry.Line;
		DueCycle.push_back(Cycle + ReadLatency);
		DuePixels.push_back(FontModel[Char[6:0] * GlyphLines + Entry.Line]);
		NextCycle();
		ReadRequest = 1'b0;
	endtask

	// Drain pending reads, then report the test
	task automatic FinishTest(input int Number);
		int Waited;
		Waited = 0;
		while (DueCycle.size() > 0 && Waited < DrainTimeout) begin
			NextCycle();
			Waited++;
		end
		if (DueCycle.size() > 0) begin
			$display("Read results still pending at the end of test %0d", Number);
			TestErrors++;
			DueCycle.delete();
			DuePixels.delete();
		end
		if (TestErrors == 0) begin
			TestsPassed++;
			$display("Test %0d (%s) passed", Number, TestNames[Number]);
		end else begin
			TestsFailed++;
			$display("Test %0d (%s) failed with %0d errors", Number, TestNames[Number],
				TestErrors);
		end
		Errors += TestErrors;
		TestErrors = 0;
	endtask

	task automatic AddStep(input int Test, input StepKind_t Kind, input logic [7:0] Data,
		input int Column, input int Row, input int Line);
		Step_t Entry;
		Entry.Test = Test;
		Entry.Kind = Kind;
		Entry.Data = Data;
		Entry.Column = Column;
		Entry.Row = Row;
		Entry.Line = Line;
		Steps.push_back(Entry);
	endtask

	task automatic BuildTable();
		// Text fills row 0 from the home position
		AddStep(2, KindSend, 8'h48, 1, 0, 0);
		AddStep(2, KindSend, 8'h4F, 2, 0, 0);
		AddStep(2, KindSend, 8'h41, 3, 0, 0);
		AddStep(2, KindSend, 8'h5A, 4, 0, 0);
		AddStep(2, KindRead, 8'h00, 0, 0, 6);
		AddStep(2, KindRead, 8'h00, 1, 0, 2);
		AddStep(2, KindRead, 8'h00, 2, 0, 3);
		AddStep(2, KindRead, 8'h00, 3, 0, 9);
		// Control codes, then text at the moved cursor
		AddStep(3, KindSend, CodeCarriageReturn, 0, 0, 0);
		AddStep(3, KindSend, CodeNewLine, 0, 1, 0);
		AddStep(3, KindSend, 8'h31, 1, 1, 0);
		AddStep(3, KindSend, CodeBackspace, 0, 1, 0);
		AddStep(3, KindSend, 8'h30, 1, 1, 0);
		AddStep(3, KindSend, CodeHome, 0, 0, 0);
		AddStep(3, KindSend, 8'h42, 1, 0, 0);
		AddStep(3, KindRead, 8'h00, 0, 1, 3);
		AddStep(3, KindRead, 8'h00, 0, 0, 7);
		// Screen edges
		AddStep(4, KindSend, CodeHome, 0, 0, 0);
		AddStep(4, KindSend, CodeBackspace, 79, 29, 0);
		AddStep(4, KindSend, 8'h41, 0, 0, 0);
		AddStep(4, KindSend, CodeNewLine, 0, 1, 0);
		AddStep(4, KindSend, CodeBackspace, 79, 0, 0);
		AddStep(4, KindSend, 8'h21, 0, 1, 0);
		AddStep(4, KindSend, CodeHome, 0, 0, 0);
		AddStep(4, KindSend, CodeBackspace, 79, 29, 0);
		AddStep(4, KindSend, CodeNewLine, 79, 0, 0);
		AddStep(4, KindRead, 8'h00, 79, 29, 6);
		AddStep(4, KindRead, 8'h00, 79, 0, 4);
		// High bytes, some shaped like control codes
		AddStep(5, KindSend, 8'hC1, 79, 0, 0);
		AddStep(5, KindSend, 8'h90, 79, 0, 0);
		AddStep(5, KindSend, 8'h88, 79, 0, 0);
		AddStep(5, KindSend, 8'hFF, 79, 0, 0);
		AddStep(5, KindRead, 8'h00, 79, 0, 5);
		AddStep(5, KindRead, 8'h00, 0, 1, 8);
		// Requests on every cycle
		AddStep(6, KindIdle, 8'h00, 0, 0, 0);
		AddStep(6, KindRead, 8'h00, 0, 0, 2);
		AddStep(6, KindRead, 8'h00, 1, 0, 11);
		AddStep(6, KindRead, 8'h00, 2, 0, 3);
		AddStep(6, KindRead, 8'h00, 3, 0, 5);
		AddStep(6, KindRead, 8'h00, 79, 29, 4);
		AddStep(6, KindRead, 8'h00, 0, 1, 7);
		AddStep(6, KindRead, 8'h00, 79, 0, 3);
		AddStep(6, KindIdle, 8'h00, 0, 0, 0);
	endtask

	initial begin
		int Index;
		int CurrentTest;
		Clock = 1'b0;
		Reset = 1'b0;
		AnalyzeRequest = 1'b0;
		DataFromUart = '0;
		ReadRequest = 1'b0;
		ReadColumn = '0;
		ReadRow = '0;
		ReadLine = '0;
		ModelColumn = '0;
		ModelRow = '0;
		Cycle = 0;
		Checks = 0;
		Errors = 0;
		TestErrors = 0;
		TestsPassed = 0;
		TestsFailed = 0;
		TestNames[1] = "reset state";
		TestNames[2] = "text write and readback";
		TestNames[3] = "cursor control codes";
		TestNames[4] = "wrap rules";
		TestNames[5] = "ignored bytes";
		TestNames[6] = "back-to-back reads";
		for (Index = 0; Index < FontDepth; Index++) begin
			FontModel[Index] = '0;
		end
		$readmemh(FontFile, FontModel);
		for (Index = 0; Index < TextDepth; Index++) begin
			ScreenModel[Index] = '0;
		end
		BuildTable();

		// Two cycles in reset
		NextCycle();
		NextCycle();
		Reset = 1'b1;
		CheckValue("Pixels_o", Pixels, 8'h00);
		CheckValue("ColorForeground_o", ColorForeground, ColorForegroundReset);
		CheckValue("ColorBackground_o", ColorBackground, ColorBackgroundReset);
		CheckValue("CursorColumn_o", CursorColumn, 8'h00);
		CheckValue("CursorRow_o", CursorRow, 8'h00);
		FinishTest(1);

		CurrentTest = Steps[0].Test;
		for (Index = 0; Index < Steps.size(); Index++) begin
			if (Steps[Index].Test != CurrentTest) begin
				FinishTest(CurrentTest);
				CurrentTest = Steps[Index].Test;
			end
			case (Steps[Index].Kind)
				KindSend: begin
					SendByte(Steps[Index]);
				end
				KindRead: begin
					ReadCell(Steps[Index]);
				end
				default: begin
					NextCycle();
				end
			endcase
		end
		FinishTest(CurrentTest);

		$display("Tests passed %0d, failed %0d, checks %0d, errors %0d", TestsPassed,
			TestsFailed, Checks, Errors);
		if (Errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== hdl/TextTerminal.sv ====
// Text terminal top level with decoder, cursor writer, RAM, ROM and pixel fetcher
`timescale 1ns/1ps

module TextTerminal (
	input logic Clock,
	input logic Reset,
	input logic AnalyzeRequest_i,
	input logic [7:0] DataFromUart_i,
	input logic ReadRequest_i,
	input logic [TextTerminalPkg::ColumnWidth-1:0] Column_i,
	input logic [TextTerminalPkg::RowWidth-1:0] Row_i,
	input logic [TextTerminalPkg::LineWidth-1:0] Line_i,
	output logic [7:0] Pixels_o,
	output logic [2:0] ColorForeground_o,
	output logic [2:0] ColorBackground_o,
	output logic [TextTerminalPkg::ColumnWidth-1:0] CursorColumn_o,
	output logic [TextTerminalPkg::RowWidth-1:0] CursorRow_o
);
	import TextTerminalPkg::*;

	Command_t Command;
	TextWrite_t TextWrite;
	ScreenPosition_t Position;
	logic [TextAddressWidth-1:0] TextReadAddress;
	logic [7:0] TextData;
	logic [FontAddressWidth-1:0] FontAddress;
	logic [7:0] FontData;

	assign Position = '{Column: Column_i, Row: Row_i, Line: Line_i};

	// Write side
	CommandDecoder Decoder (
		.AnalyzeRequest_i(AnalyzeRequest_i),
		.DataFromUart_i(DataFromUart_i),
		.Command_o(Command)
	);

	CursorWriter Writer (
		.Clock(Clock),
		.Reset(Reset),
		.Command_i(Command),
		.TextWrite_o(TextWrite),
		.CursorColumn_o(CursorColumn_o),
		.CursorRow_o(CursorRow_o)
	);

	// Storage
	TextRam #(
		.Depth(TextDepth),
		.AddressWidth(TextAddressWidth)
	) Text (
		.Clock(Clock),
		.WriteEnable_i(TextWrite.Enable),
		.WriteAddress_i(TextWrite.Address),
		.WriteData_i(TextWrite.Char),
		.ReadAddress_i(TextReadAddress),
		.ReadData_o(TextData)
	);

	FontRom Font (
		.Clock(Clock),
		.Address_i(FontAddress),
		.Data_o(FontData)
	);

	// Read side
	PixelFetcher Fetcher (
		.Clock(Clock),
		.Reset(Reset),
		.ReadRequest_i(ReadRequest_i),
		.Position_i(Position),
		.TextReadAddress_o(TextReadAddress),
		.TextData_i(TextData),
		.FontAddress_o(FontAddress),
		.FontData_i(FontData),
		.Pixels_o(Pixels_o),
		.ColorForeground_o(ColorForeground_o),
		.ColorBackground_o(ColorBackground_o)
	);

endmodule

// ==== hdl/PixelFetcher.sv ====
// Pixel read pipeline from screen position through text RAM and font ROM
`timescale 1ns/1ps

module PixelFetcher (
	input logic Clock,
	input logic Reset,
	input logic ReadRequest_i,
	input TextTerminalPkg::ScreenPosition_t Position_i,
	output logic [TextTerminalPkg::TextAddressWidth-1:0] TextReadAddress_o,
	input logic [7:0] TextData_i,
	output logic [TextTerminalPkg::FontAddressWidth-1:0] FontAddress_o,
	input logic [7:0] FontData_i,
	output logic [7:0] Pixels_o,
	output logic [2:0] ColorForeground_o,
	output logic [2:0] ColorBackground_o
);
	import TextTerminalPkg::*;

	// Valid tags, one per stage
	logic AddressValid;
	logic GlyphValid;
	logic FontValid;
	logic [TextAddressWidth-1:0] CellAddress;
	logic [LineWidth-1:0] AddressLine;
	logic [LineWidth-1:0] GlyphLine;

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			AddressValid <= 1'b0;
			GlyphValid <= 1'b0;
			FontValid <= 1'b0;
		end else begin
			AddressValid <= ReadRequest_i;
			GlyphValid <= AddressValid;
			FontValid <= GlyphValid;
		end
	end

	// Stage one, capture and linear address
	always_ff @(posedge Clock) begin
		if (ReadRequest_i) begin
			CellAddress <= TextAddressWidth'(Position_i.Row) * TextAddressWidth'(ScreenColumns)
				+ TextAddressWidth'(Position_i.Column);
			AddressLine <= Position_i.Line;
		end
		// Line follows its request while the RAM reads
		if (AddressValid) begin
			GlyphLine <= AddressLine;
		end
	end

	assign TextReadAddress_o = CellAddress;

	// Stage two, glyph address from RAM output
	assign FontAddress_o = {TextData_i[6:0], GlyphLine};

	// Stage three, result held until the next one
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			Pixels_o <= '0;
			ColorForeground_o <= ColorForegroundReset;
			ColorBackground_o <= ColorBackgroundReset;
		end else if (FontValid) begin
			Pixels_o <= FontData_i;
			ColorForeground_o <= ColorForegroundText;
			ColorBackground_o <= ColorBackgroundText;
		end
	end

endmodule

// ==== hdl/FontRom.sv ====
// Glyph ROM loaded from the font file, registered read
`timescale 1ns/1ps

module FontRom (
	input logic Clock,
	input logic [TextTerminalPkg::FontAddressWidth-1:0] Address_i,
	output logic [7:0] Data_o
);
	import TextTerminalPkg::*;

	// Address is character times 16 plus line
	logic [7:0] Glyphs [FontDepth];

	// Glyphs missing from the file stay blank
	initial begin
		for (int Index = 0; Index < FontDepth; Index++) begin
			Glyphs[Index] = '0;
		end
		$readmemh(FontFile, Glyphs);
	end

	always_ff @(posedge Clock) begin
		Data_o <= Glyphs[Address_i];
	end

endmodule

// ==== hdl/TextRam.sv ====
// Simple dual-port character RAM, registered read
`timescale 1ns/1ps

module TextRam #(
	parameter int Depth = TextTerminalPkg::TextDepth,
	parameter int AddressWidth = TextTerminalPkg::TextAddressWidth
) (
	input logic Clock,
	input logic WriteEnable_i,
	input logic [AddressWidth-1:0] WriteAddress_i,
	input logic [7:0] WriteData_i,
	input logic [AddressWidth-1:0] ReadAddress_i,
	output logic [7:0] ReadData_o
);

	// One byte per screen cell
	logic [7:0] Memory [Depth];

	// Write port
	always_ff @(posedge Clock) begin
		if (WriteEnable_i) begin
			Memory[WriteAddress_i] <= WriteData_i;
		end
	end

	// Read port, old data on a same-edge collision
	always_ff @(posedge Clock) begin
		ReadData_o <= Memory[ReadAddress_i];
	end

endmodule

// ==== hdl/CursorWriter.sv ====
// Cursor state machine with wrap rules and text RAM write request
`timescale 1ns/1ps

module CursorWriter (
	input logic Clock,
	input logic Reset,
	input TextTerminalPkg::Command_t Command_i,
	output TextTerminalPkg::TextWrite_t TextWrite_o,
	output logic [TextTerminalPkg::ColumnWidth-1:0] CursorColumn_o,
	output logic [TextTerminalPkg::RowWidth-1:0] CursorRow_o
);
	import TextTerminalPkg::*;

	typedef enum logic {
		StateIdle,
		StateWrite
	} State_t;

	State_t State;
	logic [7:0] PendingChar;
	logic [ColumnWidth-1:0] Column;
	logic [RowWidth-1:0] Row;
	logic AtLastColumn;
	logic [RowWidth-1:0] NextRow;
	logic [RowWidth-1:0] PreviousRow;
	logic [TextAddressWidth-1:0] LinearAddress;

	assign AtLastColumn = (Column == ColumnWidth'(ScreenColumns - 1));

	// Row steps with wrap at both screen edges
	assign NextRow = (Row == RowWidth'(ScreenRows - 1)) ? '0 : Row + 1'b1;
	assign PreviousRow = (Row == '0) ? RowWidth'(ScreenRows - 1) : Row - 1'b1;

	// Cell index, row major
	assign LinearAddress = TextAddressWidth'(Row) * TextAddressWidth'(ScreenColumns)
		+ TextAddressWidth'(Column);

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			State <= StateIdle;
			Column <= '0;
			Row <= '0;
		end else if (State == StateWrite) begin
			// Byte goes to RAM on this edge, cursor steps past it
			State <= StateIdle;
			if (AtLastColumn) begin
				Column <= '0;
				Row <= NextRow;
			end else begin
				Column <= Column + 1'b1;
			end
		end else if (Command_i.Valid) begin
			case (Command_i.Op)
				OpNewLine: begin
					Row <= NextRow;
				end
				OpCarriageReturn: begin
					Column <= '0;
				end
				OpBackspace: begin
					// Column 0 backs up to the end of the previous row
					if (Column == '0) begin
						Column <= ColumnWidth'(ScreenColumns - 1);
						Row <= PreviousRow;
					end else begin
						Column <= Column - 1'b1;
					end
				end
				OpHome: begin
					Column <= '0;
					Row <= '0;
				end
				OpText: begin
					State <= StateWrite;
				end
				default: begin
					State <= StateIdle;
				end
			endcase
		end
	end

	// Character held until the write cycle
	always_ff @(posedge Clock) begin
		if (Command_i.Valid && Command_i.Op == OpText) begin
			PendingChar <= Command_i.Char;
		end
	end

	assign TextWrite_o = '{Enable: State == StateWrite, Address: LinearAddress,
		Char: PendingChar};
	assign CursorColumn_o = Column;
	assign CursorRow_o = Row;

endmodule

// ==== hdl/CommandDecoder.sv ====
// Command decoder, classifies each received UART byte
`timescale 1ns/1ps

module CommandDecoder (
	input logic AnalyzeRequest_i,
	input logic [7:0] DataFromUart_i,
	output TextTerminalPkg::Command_t Command_o
);
	import TextTerminalPkg::*;

	CommandOp_t Op;

	// Control codes first, then printable range
	always_comb begin
		case (DataFromUart_i)
			CodeNewLine: begin
				Op = OpNewLine;
			end
			CodeCarriageReturn: begin
				Op = OpCarriageReturn;
			end
			CodeBackspace: begin
				Op = OpBackspace;
			end
			CodeHome: begin
				Op = OpHome;
			end
			default: begin
				// Top bit set is ignored
				Op = DataFromUart_i[7] ? OpNone : OpText;
			end
		endcase
	end

	// Valid only in the strobe cycle
	assign Command_o = '{Valid: AnalyzeRequest_i, Op: Op, Char: DataFromUart_i};

endmodule

// ==== hdl/TextTerminalPkg.sv ====
// Screen geometry, control codes, colors, command opcodes and bus structs
package TextTerminalPkg;

	// Screen and glyph geometry
	localparam int ScreenColumns = 80;
	localparam int ScreenRows = 30;
	localparam int GlyphLines = 16;
	localparam int TextDepth = ScreenColumns * ScreenRows;
	// 128 glyphs of 16 lines each
	localparam int FontDepth = 2048;

	// Field widths
	localparam int ColumnWidth = 7;
	localparam int RowWidth = 5;
	localparam int LineWidth = 4;
	localparam int TextAddressWidth = 12;
	localparam int FontAddressWidth = 11;

	// Control codes as sent by the UART host
	localparam logic [7:0] CodeNewLine = 8'h10;
	localparam logic [7:0] CodeCarriageReturn = 8'h13;
	localparam logic [7:0] CodeBackspace = 8'h08;
	localparam logic [7:0] CodeHome = 8'h1B;

	// Fixed colors, before and after the first pixel result
	localparam logic [2:0] ColorForegroundReset = 3'b111;
	localparam logic [2:0] ColorBackgroundReset = 3'b000;
	localparam logic [2:0] ColorForegroundText = 3'b011;
	localparam logic [2:0] ColorBackgroundText = 3'b001;

	// Hex glyph data, one byte per line
	localparam FontFile = "font.mem";

	typedef enum logic [2:0] {
		OpNone,
		OpNewLine,
		OpCarriageReturn,
		OpBackspace,
		OpHome,
		OpText
	} CommandOp_t;

	// Decoded byte
	typedef struct packed {
		logic Valid;
		CommandOp_t Op;
		logic [7:0] Char;
	} Command_t;

	// Write request to the text RAM
	typedef struct packed {
		logic Enable;
		logic [TextAddressWidth-1:0] Address;
		logic [7:0] Char;
	} TextWrite_t;

	// Pixel request from the video scanner
	typedef struct packed {
		logic [ColumnWidth-1:0] Column;
		logic [RowWidth-1:0] Row;
		logic [LineWidth-1:0] Line;
	} ScreenPosition_t;

endpackage
